/* rtl/apuPkg.sv */
// ####################
// Sizes, opcode and state enums
// Instruction word and bus structs
// ####################

package apuPkg;

    localparam int dataWidth    = 16;  // Registers and data words
    localparam int instrWidth   = 8;   // One instruction in the low byte of a block RAM word
    localparam int bramDepth    = 256; // Program plus scratch data
    localparam int pcWidth      = 8;   // Covers the whole block RAM
    localparam int regCount     = 4;   // R0..R3
    localparam int programStart = 0;   // First instruction after reset

    // Opcode sits in bits 7:4 of the instruction word
    typedef enum logic [3:0] {
        ADD   = 4'b0000,
        MUL   = 4'b0001, // B is fixed point with 4 fraction bits
        LOAD  = 4'b0010, // Address in A, data into src2
        STORE = 4'b0011, // Address in A, data from B
        JMP   = 4'b0100,
        CMP   = 4'b0101, // Target = (B == 0)
        DEC   = 4'b0110, // One-hot of A[3:0]
        BEZ   = 4'b0111, // Jump to B when A is zero
        SET   = 4'b1000  // Lowest SET code since any word with bit 7 set is SET
    } opcode_t;

    typedef enum logic [1:0] {
        FETCH   = 2'd0,
        EXECUTE = 2'd1,
        WAITMEM = 2'd2
    } cpuState_t;

    typedef struct packed {
        opcode_t    opcode; // Bits 7:4
        logic [1:0] src1;   // Target and first source
        logic [1:0] src2;   // Second source and load target
    } instr_t;

    typedef struct packed {
        logic                 valid;
        logic                 write;
        logic [dataWidth-1:0] addr;
        logic [dataWidth-1:0] wdata;
    } ramReq_t;

    typedef struct packed {
        logic                 ready; // Ends the transfer
        logic [dataWidth-1:0] rdata; // Valid with ready on reads
    } ramRsp_t;

    typedef struct packed {
        logic                 en;
        logic                 write;
        logic [pcWidth-1:0]   addr;
        logic [dataWidth-1:0] wdata;
    } bramReq_t;

    typedef struct packed {
        logic [dataWidth-1:0] result;      // ALU value or branch target
        logic                 writeEn;     // Result goes to a register
        logic                 branchTaken; // Result replaces pc + 1
    } aluOut_t;

endpackage

/* rtl/apuAlu.sv */
// ####################
// Combinational execute unit
// ####################

module apuAlu
    import apuPkg::*;
(
    input  instr_t               instr,
    input  logic [dataWidth-1:0] a,
    input  logic [dataWidth-1:0] b,
    output aluOut_t              out
);

    logic [2*dataWidth-1:0] product; // Full width before the fixed point shift
    logic [6:0]             imm;     // SET immediate from bits 6:0 of the word

    assign product = {{dataWidth{1'b0}}, a} * {{dataWidth{1'b0}}, b};
    assign imm     = {instr.opcode[2:0], instr.src1, instr.src2};

    always_comb begin
        out = '0;
        if (instr.opcode >= SET) begin
            out.result  = {{(dataWidth-7){1'b0}}, imm}; // Zero extended
            out.writeEn = 1'b1;                         // Control routes it to R3
        end else begin
            case (instr.opcode)
                ADD: begin
                    out.result  = a + b; // Wraps modulo 2^16
                    out.writeEn = 1'b1;
                end
                MUL: begin
                    out.result  = product[dataWidth+3:4]; // Drop fraction bits and truncate top
                    out.writeEn = 1'b1;
                end
                CMP: begin
                    out.result  = {{(dataWidth-1){1'b0}}, (b == '0)};
                    out.writeEn = 1'b1;
                end
                DEC: begin
                    out.result  = {{(dataWidth-1){1'b0}}, 1'b1} << a[3:0];
                    out.writeEn = 1'b1;
                end
                JMP: begin
                    out.result      = a; // Target carried on result
                    out.branchTaken = 1'b1;
                end
                BEZ: begin
                    out.result      = b;
                    out.branchTaken = (a == '0);
                end
                default: begin
                    // LOAD and STORE are sequenced by the control unit
                    out.result = a;
                end
            endcase
        end
    end

endmodule

/* rtl/apuRegFile.sv */
// ####################
// Four 16-bit registers
// Two async reads, one sync write
// ####################

module apuRegFile
    import apuPkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic [1:0]           rdIdxA,
    input  logic [1:0]           rdIdxB,
    output logic [dataWidth-1:0] rdA,
    output logic [dataWidth-1:0] rdB,
    input  logic [1:0]           wrIdx,
    input  logic [dataWidth-1:0] wrData,
    input  logic                 wrEn
);

    logic [dataWidth-1:0] regs [regCount];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < regCount; i++) begin
                regs[i] <= '0; // All registers start at zero
            end
        end else if (wrEn) begin
            regs[wrIdx] <= wrData;
        end
    end

    assign rdA = regs[rdIdxA]; // Operand A and memory address
    assign rdB = regs[rdIdxB]; // Operand B and store data

endmodule

/* rtl/apuControl.sv */
// ####################
// Fetch/execute FSM, program counter
// Register writeback, memory requests
// ####################

module apuControl
    import apuPkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    output instr_t               instr,
    input  logic [dataWidth-1:0] rdA,
    input  logic [dataWidth-1:0] rdB,
    input  aluOut_t              alu,
    output logic [1:0]           wrIdx,
    output logic [dataWidth-1:0] wrData,
    output logic                 wrEn,
    output bramReq_t             bramReq,
    input  logic [dataWidth-1:0] bramRdata,
    output ramReq_t              ramReq,
    input  ramRsp_t              ramRsp
);

    cpuState_t          state;
    logic [pcWidth-1:0] pc;       // Points at the current instruction
    instr_t             instrReg; // Held for WAITMEM while the block RAM output moves on
    logic               isSet;
    logic               isLoad;
    logic               isStore;
    logic               isMem;
    logic               isExt;    // Off chip access when src1 is R0
    logic               extBusy;  // External request on the bus this cycle
    logic               retire;   // Instruction finishes at this edge

    // Fetched word sits on the block RAM output during EXECUTE only
    always_comb begin
        instr = instrReg;
        if (state == EXECUTE) begin
            instr = instr_t'(bramRdata[instrWidth-1:0]);
        end
    end

    assign isSet   = (instr.opcode >= SET);
    assign isLoad  = (instr.opcode == LOAD);
    assign isStore = (instr.opcode == STORE);
    assign isMem   = isLoad || isStore;
    assign isExt   = (instr.src1 == 2'd0);

    always_comb begin
        bramReq = '0;
        ramReq  = '0;
        extBusy = 1'b0;
        retire  = 1'b0;
        wrEn    = 1'b0;
        wrIdx   = isSet ? 2'd3 : instr.src1; // SET always targets R3
        wrData  = alu.result;
        case (state) // Bus stays idle in an unknown state
            FETCH: begin
                bramReq.en   = 1'b1;
                bramReq.addr = pc;
            end
            EXECUTE: begin
                if (!isMem) begin
                    wrEn   = alu.writeEn;
                    retire = 1'b1;
                end else if (isExt) begin
                    extBusy = 1'b1;
                end else begin
                    bramReq.en    = 1'b1;
                    bramReq.write = isStore;
                    bramReq.addr  = rdA[pcWidth-1:0]; // Block RAM uses the low address bits
                    bramReq.wdata = rdB;
                end
            end
            WAITMEM: begin
                if (isExt) begin
                    extBusy = 1'b1; // Hold the request until ready
                end else begin
                    retire = 1'b1;  // Block RAM read data is here now
                    wrIdx  = instr.src2;
                    wrData = bramRdata;
                    wrEn   = isLoad;
                end
            end
            default: begin
            end
        endcase
        if (extBusy) begin
            // Fields come from held registers and stay stable while waiting
            ramReq.valid = 1'b1;
            ramReq.write = isStore;
            ramReq.addr  = rdA;
            ramReq.wdata = rdB;
            retire       = ramRsp.ready;
            if (isLoad) begin
                wrIdx  = instr.src2;
                wrData = ramRsp.rdata;
                wrEn   = ramRsp.ready;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= FETCH;
            pc       <= pcWidth'(programStart);
            instrReg <= '0;
        end else begin
            case (state)
                FETCH: begin
                    state <= EXECUTE;
                end
                EXECUTE: begin
                    instrReg <= instr;                   // Keep the word past the block RAM read
                    state    <= retire ? FETCH : WAITMEM; // Early ready ends an external access
                end
                WAITMEM: begin
                    if (retire) begin
                        state <= FETCH;
                    end
                end
                default: begin
                    state <= FETCH;
                end
            endcase
            if (retire) begin
                pc <= alu.branchTaken ? alu.result[pcWidth-1:0] : pc + 1'b1;
            end
        end
    end

endmodule

/* rtl/apuBram.sv */
// ####################
// 256x16 block RAM, registered read
// ####################

module apuBram
    import apuPkg::*;
(
    input  logic                 clk,
    input  bramReq_t             req,
    output logic [dataWidth-1:0] rdata
);

    logic [dataWidth-1:0] mem [bramDepth]; // Program and scratch words kept across reset

    always_ff @(posedge clk) begin
        if (req.en) begin
            if (req.write) begin
                mem[req.addr] <= req.wdata;
            end
            rdata <= mem[req.addr]; // Read-first with data one cycle after en
        end
    end

endmodule

/* rtl/apuTop.sv */
// ####################
// APU top level
// External RAM bus, program load port
// ####################

module apuTop
    import apuPkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  bramReq_t progLoad,
    output ramReq_t  ramReq,
    input  ramRsp_t  ramRsp
);

    instr_t               instr;
    aluOut_t              aluOut;
    logic [dataWidth-1:0] rdA;
    logic [dataWidth-1:0] rdB;
    logic [1:0]           wrIdx;
    logic [dataWidth-1:0] wrData;
    logic                 wrEn;
    bramReq_t             coreReq;   // Fetch and data accesses from the core
    bramReq_t             bramReq;   // What the block RAM actually sees
    logic [dataWidth-1:0] bramRdata;

    assign bramReq = rst ? progLoad : coreReq; // Loader owns the RAM while in reset

    apuControl uControl (
        .clk      (clk),
        .rst      (rst),
        .instr    (instr),
        .rdA      (rdA),
        .rdB      (rdB),
        .alu      (aluOut),
        .wrIdx    (wrIdx),
        .wrData   (wrData),
        .wrEn     (wrEn),
        .bramReq  (coreReq),
        .bramRdata(bramRdata),
        .ramReq   (ramReq),
        .ramRsp   (ramRsp)
    );

    apuRegFile uRegFile (
        .clk   (clk),
        .rst   (rst),
        .rdIdxA(instr.src1),
        .rdIdxB(instr.src2),
        .rdA   (rdA),
        .rdB   (rdB),
        .wrIdx (wrIdx),
        .wrData(wrData),
        .wrEn  (wrEn)
    );

    apuAlu uAlu (
        .instr(instr),
        .a    (rdA),
        .b    (rdB),
        .out  (aluOut)
    );

    apuBram uBram (
        .clk  (clk),
        .req  (bramReq),
        .rdata(bramRdata)
    );

endmodule

/* tests/apuBus_checker.sv */
// ####################
// External RAM bus assertions
// Bound into apuTop
// ####################

module apuBusChecker
    import apuPkg::*;
(
    input logic    clk,
    input logic    rst,
    input ramReq_t ramReq,
    input ramRsp_t ramRsp
);

    timeunit 1ns;
    timeprecision 100ps;

    int assertFails = 0; // Failure count seen from the testbench

    validInReset: assert property (@(posedge clk) rst |-> !ramReq.valid)
        else begin
            assertFails++;
            $error("ramReq.valid high during reset");
        end

    // Request fields hold until the ready cycle
    holdRequest: assert property (@(posedge clk) disable iff (rst)
        ramReq.valid && !ramRsp.ready |=> ramReq.valid && $stable(ramReq.addr)
            && $stable(ramReq.write) && $stable(ramReq.wdata))
        else begin
            assertFails++;
            $error("ramReq changed or dropped before ready");
        end

    validKnown: assert property (@(posedge clk) !$isunknown(ramReq.valid))
        else begin
            assertFails++;
            $error("ramReq.valid is unknown");
        end

endmodule

bind apuTop apuBusChecker uBusChecker (
    .clk   (clk),
    .rst   (rst),
    .ramReq(ramReq),
    .ramRsp(ramRsp)
);

/* tests/apuTb.sv */
// ####################
// Directed testbench for the APU
// External RAM model with LFSR ready delays, program loader, tests
// ####################

module apuTb
    import apuPkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int          resetCycles = 5;
    localparam int          worstCycles = 7;  // FETCH, EXECUTE, two model cycles, three delay
    localparam logic [31:0] lfsrTaps    = 32'h8020_0003;

    logic        clk = 1'b0;
    logic        rst;
    bramReq_t    progLoad;
    ramReq_t     ramReq;
    ramRsp_t     ramRsp;
    logic [7:0]  prog[$];           // Program under construction
    logic [15:0] extMem [256];      // External RAM indexed by the low address byte
    logic [15:0] wrAddr[$];         // Completed external writes
    logic [15:0] wrData[$];
    logic [15:0] expAddr[$];
    logic [15:0] expData[$];
    logic [31:0] lfsr = 32'h3548;
    logic        pending;           // Request seen and delay already drawn
    int          waitCnt;
    int          extAddr;           // Tracks R0 while a program is built
    int          cycleCount = 0;
    int          cycleBudget = 40;
    int          errors = 0;
    int          testsRun = 0;
    int          testsFailed = 0;

    apuTop UUT (
        .clk     (clk),
        .rst     (rst),
        .progLoad(progLoad),
        .ramReq  (ramReq),
        .ramRsp  (ramRsp)
    );

    always #4 clk = ~clk;

    function automatic logic randomBit();
        logic outBit;
        outBit = lfsr[0];
        lfsr   = lfsr >> 1;
        if (outBit) begin
            lfsr = lfsr ^ lfsrTaps; // Galois feedback
        end
        return outBit;
    endfunction

    // External RAM model with ready after 0 to 3 extra cycles
    always @(posedge clk) begin
        logic [1:0] delay;
        if (rst) begin
            ramRsp  <= '0;
            pending <= 1'b0;
        end else if (ramReq.valid && ramRsp.ready) begin
            if (ramReq.write) begin
                extMem[ramReq.addr[7:0]] = ramReq.wdata;
                wrAddr.push_back(ramReq.addr);
                wrData.push_back(ramReq.wdata);
            end
            ramRsp.ready <= 1'b0; // Transfer ends at this edge
            pending      <= 1'b0;
        end else if (ramReq.valid && !pending) begin
            delay[1] = randomBit();
            delay[0] = randomBit();
            waitCnt <= delay;
            pending <= 1'b1;
        end else if (ramReq.valid) begin
            if (waitCnt == 0) begin
                ramRsp.ready <= 1'b1;
                ramRsp.rdata <= extMem[ramReq.addr[7:0]];
            end else begin
                waitCnt <= waitCnt - 1;
            end
        end
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount > cycleBudget) begin
            $display("Run timed out after %0d cycles, a program never finished", cycleCount);
            $display(">>> FAIL");
            $finish;
        end
    end

    function automatic logic [7:0] encode(input opcode_t code, input int s1, input int s2);
        return {code, 2'(s1), 2'(s2)};
    endfunction

    function automatic logic [7:0] setImm(input int value);
        return {1'b1, 7'(value)}; // Lands in R3
    endfunction

    task automatic startProgram();
        prog.delete();
        expAddr.delete();
        expData.delete();
        extAddr = 0; // R0 is cleared by reset
    endtask

    task automatic addExtStore(input int step, input int srcReg, input logic [15:0] value);
        extAddr += step;
        prog.push_back(setImm(step));
        prog.push_back(encode(ADD, 0, 3));        // R0 moves to the next address
        prog.push_back(encode(STORE, 0, srcReg));
        expAddr.push_back(16'(extAddr));
        expData.push_back(value);
    endtask

    task automatic addSelfLoop();
        prog.push_back(setImm(prog.size() + 1)); // Address of the JMP below
        prog.push_back(encode(JMP, 3, 0));
    endtask

    task automatic runProgram(input string name);
        int bad;
        bad = 0;
        cycleBudget += prog.size() * (worstCycles + 1) + resetCycles + 30;
        @(posedge clk);
        rst <= 1'b1;
        for (int i = 0; i < prog.size(); i++) begin
            @(posedge clk);
            progLoad <= '{en: 1'b1, write: 1'b1, addr: 8'(i), wdata: 16'(prog[i])};
        end
        @(posedge clk);
        progLoad <= '0;
        repeat (resetCycles) @(posedge clk);
        wrAddr.delete();
        wrData.delete();
        rst <= 1'b0;
        while (wrAddr.size() < expAddr.size()) @(negedge clk);
        repeat (4) @(negedge clk); // Room for a stray write to show up
        if (wrAddr.size() != expAddr.size()) begin
            $display("%s: %0d external writes seen, %0d expected", name, wrAddr.size(),
                     expAddr.size());
            bad++;
        end
        for (int i = 0; i < expAddr.size(); i++) begin
            if (wrAddr[i] !== expAddr[i]) begin
                $display("MISMATCH %s write %0d addr: expected %h, actual %h", name, i,
                         expAddr[i], wrAddr[i]);
                bad++;
            end
            if (wrData[i] !== expData[i]) begin
                $display("MISMATCH %s write %0d data: expected %h, actual %h", name, i,
                         expData[i], wrData[i]);
                bad++;
            end
        end
        testsRun++;
        errors += bad;
        if (bad == 0) begin
            $display("%s: ok", name);
        end else begin
            testsFailed++;
            $display("%s: failed with %0d errors", name, bad);
        end
    endtask

    task automatic setAddSums();
        startProgram();
        prog.push_back(setImm(25));
        prog.push_back(encode(ADD, 1, 3)); // R1 = 25
        prog.push_back(setImm(100));
        prog.push_back(encode(ADD, 2, 3)); // R2 = 100
        prog.push_back(encode(ADD, 1, 2)); // R1 = 125
        addExtStore(16, 1, 16'(25 + 100));
        prog.push_back(encode(ADD, 2, 1)); // R2 = 225
        addExtStore(1, 2, 16'(100 + 125));
        for (int i = 0; i < 10; i++) begin
            prog.push_back(encode(ADD, 1, 1)); // Doubling wraps past 16 bits
        end
        addExtStore(1, 1, 16'(125 * 1024));
        addSelfLoop();
        runProgram("set_add");
    endtask

    task automatic fixedPointMul();
        logic [15:0] a;
        startProgram();
        a = 16'd127;
        prog.push_back(setImm(127));
        prog.push_back(encode(ADD, 1, 3));
        prog.push_back(encode(ADD, 2, 3)); // R2 = 127 or 7.9375 in fixed point
        for (int i = 0; i < 4; i++) begin
            a = 16'((32'(a) * 127) >> 4); // Last pass overflows 16 bits
            prog.push_back(encode(MUL, 1, 2));
            addExtStore((i == 0) ? 32 : 1, 1, a);
        end
        addSelfLoop();
        runProgram("mul_fixed");
    endtask

    task automatic extLoadStore();
        logic [15:0] words [4];
        startProgram();
        words = '{16'h1234, 16'hBEEF, 16'h00FF, 16'hFFFE};
        prog.push_back(setImm(5));
        prog.push_back(encode(ADD, 2, 3)); // R2 = constant added
        prog.push_back(setImm(64));
        prog.push_back(encode(ADD, 0, 3)); // R0 = first word
        for (int i = 0; i < 4; i++) begin
            extMem[64 + i] = words[i];
            prog.push_back(encode(LOAD, 0, 1));  // R1 = ext[R0]
            prog.push_back(encode(ADD, 1, 2));
            prog.push_back(encode(STORE, 0, 1)); // Written back in place
            expAddr.push_back(16'(64 + i));
            expData.push_back(words[i] + 16'd5);
            prog.push_back(setImm(1));
            prog.push_back(encode(ADD, 0, 3));
        end
        addSelfLoop();
        runProgram("ext_load_store");
    endtask

    task automatic bramCmpDecode();
        logic [15:0] value;
        logic        isZero;
        startProgram();
        value  = 16'd9;
        isZero = (value == 0);
        prog.push_back(setImm(100));
        prog.push_back(encode(ADD, 1, 3));   // R1 = block RAM address
        prog.push_back(setImm(value));
        prog.push_back(encode(ADD, 2, 3));
        prog.push_back(encode(STORE, 1, 2)); // Block RAM write
        prog.push_back(encode(CMP, 2, 1));   // R2 cleared before the load
        prog.push_back(encode(LOAD, 1, 2));  // R2 = value read back
        prog.push_back(encode(CMP, 1, 2));
        addExtStore(48, 1, 16'(isZero));
        prog.push_back(encode(CMP, 1, 1));   // Compare of the previous result
        addExtStore(1, 1, 16'(!isZero));
        prog.push_back(encode(DEC, 2, 0));
        addExtStore(1, 2, 16'd1 << value[3:0]);
        addSelfLoop();
        runProgram("bram_cmp_dec");
    endtask

    task automatic branchOnZero(input logic [6:0] cond);
        string name;
        startProgram();
        prog.push_back(setImm(4));
        prog.push_back(encode(JMP, 3, 0));   // Skips the stray store
        prog.push_back(setImm(127));
        prog.push_back(encode(STORE, 0, 3));
        prog.push_back(setImm(80));
        prog.push_back(encode(ADD, 0, 3));   // R0 = marker address
        prog.push_back(setImm(cond));
        prog.push_back(encode(ADD, 1, 3));   // R1 = value tested by BEZ
        prog.push_back(setImm(15));
        prog.push_back(encode(ADD, 2, 3));   // R2 = taken target
        prog.push_back(encode(BEZ, 1, 2));
        prog.push_back(setImm(17));          // Fall through marker
        prog.push_back(encode(STORE, 0, 3));
        addSelfLoop();
        prog.push_back(setImm(34));          // Taken marker at word 15
        prog.push_back(encode(STORE, 0, 3));
        addSelfLoop();
        expAddr.push_back(16'd80);
        if (cond == 0) begin
            expData.push_back(16'd34);
            name = "bez_taken";
        end else begin
            expData.push_back(16'd17);
            name = "bez_not_taken";
        end
        runProgram(name);
    endtask

    initial begin
        rst      = 1'b1;
        progLoad = '0;
        ramRsp   = '0;
        repeat (resetCycles) @(posedge clk);
        setAddSums();
        fixedPointMul();
        extLoadStore();
        bramCmpDecode();
        branchOnZero(7'd0);
        branchOnZero(7'd7);
        if (UUT.uBusChecker.assertFails != 0) begin
            $display("Bus checker assertions failed %0d times", UUT.uBusChecker.assertFails);
            errors += UUT.uBusChecker.assertFails;
        end
        $display("Tests run %0d, failed %0d, errors %0d", testsRun, testsFailed, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* vlog.f */
rtl/apuPkg.sv
rtl/apuAlu.sv
rtl/apuRegFile.sv
rtl/apuControl.sv
rtl/apuBram.sv
rtl/apuTop.sv
tests/apuBus_checker.sv
tests/apuTb.sv

/* Bender.yml */
package:
  name: apu

sources:
  - files:
      - rtl/apuPkg.sv
      - rtl/apuAlu.sv
      - rtl/apuRegFile.sv
      - rtl/apuControl.sv
      - rtl/apuBram.sv
      - rtl/apuTop.sv
  - target: test
    files:
      - tests/apuBus_checker.sv
      - tests/apuTb.sv
